// ==== hw/decode_unit.sv ====
// Decode stage that splits instruction fields, resolves jumps and registers the decoded bundle
`timescale 1ns/10ps

module decode_unit
   import fetch_pkg::*;
(
   input  logic      clk,
   input  logic      rst,
   input  logic      stall,
   input  fetch_t    id_in,
   output redirect_t redirect,
   output decoded_t  dec_out
);

   instr_t   ins;
   opcode_e  op;
   word_t    imm_sext;
   word_t    jmp_ofs;
   decoded_t dec_next;

   assign ins = id_in.instr;

   // Opcode sits in the same place in both views
   assign op = ins.r_fmt.opcode;

   // Sign-extended imm8 and its halfword-scaled byte offset
   assign imm_sext = {{(WORD_W - IMM_W){ins.i_fmt.imm8[IMM_W-1]}}, ins.i_fmt.imm8};
   assign jmp_ofs  = {imm_sext[WORD_W-2:0], 1'b0};

   // Relative jump, taken only while the pipe moves
   always_comb begin
      redirect.valid  = id_in.valid && (op == OP_JMP) && !stall;
      redirect.target = id_in.pc + PC_STEP + jmp_ofs;
   end

   // Field split and class flags
   always_comb begin
      dec_next        = '0;
      dec_next.valid  = id_in.valid;
      dec_next.pc     = id_in.pc;
      dec_next.opcode = op;
      // Non-ALU classes pass through
      dec_next.alu_op = ALU_PASS;

      case (op)
         // Register ALU ops, three registers from the r_fmt view
         OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL, OP_SLT: begin
            case (op)
               OP_ADD:  dec_next.alu_op = ALU_ADD;
               OP_SUB:  dec_next.alu_op = ALU_SUB;
               OP_AND:  dec_next.alu_op = ALU_AND;
               OP_OR:   dec_next.alu_op = ALU_OR;
               OP_XOR:  dec_next.alu_op = ALU_XOR;
               OP_SLL:  dec_next.alu_op = ALU_SLL;
               OP_SRL:  dec_next.alu_op = ALU_SRL;
               default: dec_next.alu_op = ALU_SLT;
            endcase
            dec_next.rd = ins.r_fmt.rd;
            dec_next.rs = ins.r_fmt.rs;
            dec_next.rt = ins.r_fmt.rt;
         end
         OP_ADDI: begin
            dec_next.alu_op   = ALU_ADD;
            dec_next.rd       = ins.i_fmt.rd;
            dec_next.imm      = imm_sext;
            dec_next.uses_imm = 1'b1;
         end
         OP_LUI: begin
            // Immediate goes to the upper byte, ALU just forwards it
            dec_next.alu_op   = ALU_PASS;
            dec_next.rd       = ins.i_fmt.rd;
            dec_next.imm      = {ins.i_fmt.imm8, {(WORD_W - IMM_W){1'b0}}};
            dec_next.uses_imm = 1'b1;
         end
         OP_LD: begin
            // Address add uses the sign-extended offset
            dec_next.alu_op   = ALU_ADD;
            dec_next.rd       = ins.i_fmt.rd;
            dec_next.imm      = imm_sext;
            dec_next.uses_imm = 1'b1;
            dec_next.is_load  = 1'b1;
         end
         OP_ST: begin
            // rd names the store data register
            dec_next.alu_op   = ALU_ADD;
            dec_next.rd       = ins.i_fmt.rd;
            dec_next.imm      = imm_sext;
            dec_next.uses_imm = 1'b1;
            dec_next.is_store = 1'b1;
         end
         OP_JMP: begin
            // Byte offset reported for tracing, target already sent to fetch
            dec_next.imm     = jmp_ofs;
            dec_next.is_jump = 1'b1;
         end
         OP_NOP: begin
            // Valid bundle with every field cleared
         end
         default: begin
            dec_next.illegal = 1'b1;
         end
      endcase
   end

   // Output register, a stalled edge emits a bubble
   always_ff @(posedge clk) begin
      if (!stall) begin
         dec_out <= dec_next;
      end
      if (rst || stall) begin
         dec_out.valid <= 1'b0;
      end
   end

   // Target stays halfword aligned as long as fetch hands over even PCs
   target_even_a : assert property (
      @(posedge clk) disable iff (rst)
      redirect.valid |-> (redirect.target[0] == 1'b0)
   ) else $error("decode_unit: odd jump target %h", redirect.target);

endmodule

// ==== hw/fetch_pkg.sv ====
// Front-end package with instruction views, opcode encodings and pipeline bundles
package fetch_pkg;

   // Word and field widths
   localparam int WORD_W = 16;
   localparam int OPC_W  = 4;
   localparam int REG_W  = 4;
   localparam int IMM_W  = 8;

   // Byte step between consecutive instructions
   localparam logic [WORD_W-1:0] PC_STEP = 16'd2;

   typedef logic [WORD_W-1:0] word_t;

   // Opcode map, codes 12 and 14 are unassigned
   typedef enum logic [OPC_W-1:0] {
      OP_ADD  = 4'd0,
      OP_SUB  = 4'd1,
      OP_AND  = 4'd2,
      OP_OR   = 4'd3,
      OP_XOR  = 4'd4,
      OP_SLL  = 4'd5,
      OP_SRL  = 4'd6,
      OP_SLT  = 4'd7,
      OP_ADDI = 4'd8,
      OP_LUI  = 4'd9,
      OP_LD   = 4'd10,
      OP_ST   = 4'd11,
      OP_JMP  = 4'd13,
      OP_NOP  = 4'd15
   } opcode_e;

   // Operation select for the downstream ALU
   typedef enum logic [3:0] {
      ALU_ADD  = 4'd0,
      ALU_SUB  = 4'd1,
      ALU_AND  = 4'd2,
      ALU_OR   = 4'd3,
      ALU_XOR  = 4'd4,
      ALU_SLL  = 4'd5,
      ALU_SRL  = 4'd6,
      ALU_SLT  = 4'd7,
      ALU_PASS = 4'd8
   } alu_op_e;

   // Register format: three register specifiers
   typedef struct packed {
      opcode_e            opcode;
      logic [REG_W-1:0]   rd;
      logic [REG_W-1:0]   rs;
      logic [REG_W-1:0]   rt;
   } r_fmt_t;

   // Immediate format: one register and an 8-bit immediate
   typedef struct packed {
      opcode_e            opcode;
      logic [REG_W-1:0]   rd;
      logic [IMM_W-1:0]   imm8;
   } i_fmt_t;

   // Same instruction word seen through either format
   typedef union packed {
      r_fmt_t r_fmt;
      i_fmt_t i_fmt;
   } instr_t;

   // Fetched instruction with its byte address, 33 bits
   typedef struct packed {
      word_t  pc;
      instr_t instr;
      logic   valid;
   } fetch_t;

   // Jump redirect from decode back to fetch, 17 bits
   typedef struct packed {
      logic  valid;
      word_t target;
   } redirect_t;

   // One decoded instruction for the back end
   typedef struct packed {
      logic             valid;
      word_t            pc;
      opcode_e          opcode;
      alu_op_e          alu_op;
      logic [REG_W-1:0] rd;
      logic [REG_W-1:0] rs;
      logic [REG_W-1:0] rt;
      word_t            imm;
      logic             uses_imm;
      logic             is_load;
      logic             is_store;
      logic             is_jump;
      logic             illegal;
   } decoded_t;

endpackage

// ==== hw/fetch_top.sv ====
// Processor front end joining fetch, instruction memory, pipeline register and decode
`timescale 1ns/10ps

module fetch_top
   import fetch_pkg::*;
#(
   parameter int ROM_WORDS = 256
) (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         stall,
   input  logic                         load_en,
   input  logic [$clog2(ROM_WORDS)-1:0] load_addr,
   input  word_t                        load_data,
   output decoded_t                     dec_out
);

   word_t     fetch_addr;
   word_t     fetch_word;
   fetch_t    fetch_out;
   fetch_t    id_in;
   redirect_t redirect;

   instr_rom #(
      .ROM_WORDS (ROM_WORDS)
   ) rom_i (
      .clk        (clk),
      .load_en    (load_en),
      .load_addr  (load_addr),
      .load_data  (load_data),
      .fetch_addr (fetch_addr),
      .fetch_word (fetch_word)
   );

   fetch_unit fetch_i (
      .clk        (clk),
      .rst        (rst),
      .stall      (stall),
      .redirect   (redirect),
      .fetch_addr (fetch_addr),
      .fetch_word (fetch_word),
      .fetch_out  (fetch_out)
   );

   if_id_reg if_id_i (
      .clk       (clk),
      .rst       (rst),
      .stall     (stall),
      .fetch_out (fetch_out),
      .id_in     (id_in)
   );

   decode_unit decode_i (
      .clk      (clk),
      .rst      (rst),
      .stall    (stall),
      .id_in    (id_in),
      .redirect (redirect),
      .dec_out  (dec_out)
   );

   // Program is only loaded while the core is held in reset
   load_in_reset_a : assert property (
      @(posedge clk)
      load_en |-> rst
   ) else $error("fetch_top: memory load outside reset");

endmodule

// ==== hw/fetch_unit.sv ====
// Fetch stage holding the program counter, with jump redirect, stall hold and wrong-path squash
`timescale 1ns/10ps

module fetch_unit
   import fetch_pkg::*;
(
   input  logic      clk,
   input  logic      rst,
   input  logic      stall,
   input  redirect_t redirect,
   output word_t     fetch_addr,
   input  word_t     fetch_word,
   output fetch_t    fetch_out
);

   // Byte program counter
   word_t pc;
   word_t pc_next;

   // Next PC select
   always_comb begin
      if (redirect.valid) begin
         // Jump resolved in decode takes priority
         pc_next = redirect.target;
      end else if (stall) begin
         // Freeze on back-pressure
         pc_next = pc;
      end else begin
         // Sequential step of one instruction
         pc_next = pc + PC_STEP;
      end
   end

   // PC register
   always_ff @(posedge clk) begin
      if (rst) begin
         pc <= '0;
      end else begin
         pc <= pc_next;
      end
   end

   // Memory is addressed directly by the current PC
   assign fetch_addr = pc;

   // Outgoing fetch bundle
   always_comb begin
      fetch_out.pc    = pc;
      fetch_out.instr = instr_t'(fetch_word);
      // Word at pc is behind a taken jump when a redirect is active
      fetch_out.valid = !redirect.valid;
   end

   // Decode only redirects when the pipe is moving
   redirect_no_stall_a : assert property (
      @(posedge clk) disable iff (rst)
      !(redirect.valid && stall)
   ) else $error("fetch_unit: redirect asserted while stalled");

   // Instructions are halfword aligned, so jump targets must keep PC even
   pc_even_a : assert property (
      @(posedge clk) disable iff (rst)
      pc[0] == 1'b0
   ) else $error("fetch_unit: program counter is odd (%h)", pc);

endmodule

// ==== hw/if_id_reg.sv ====
// Fetch to decode pipeline register with stall hold and reset clear of valid
`timescale 1ns/10ps

module if_id_reg
   import fetch_pkg::*;
(
   input  logic   clk,
   input  logic   rst,
   input  logic   stall,
   input  fetch_t fetch_out,
   output fetch_t id_in
);

   // Capture when the pipe moves and hold otherwise
   always_ff @(posedge clk) begin
      if (!stall) begin
         id_in <= fetch_out;
      end
      // Reset clears the valid bit
      if (rst) begin
         id_in.valid <= 1'b0;
      end
   end

endmodule

// ==== hw/instr_rom.sv ====
// Instruction memory with a boot-load write port and an asynchronous fetch read
`timescale 1ns/10ps

module instr_rom
   import fetch_pkg::*;
#(
   parameter int ROM_WORDS = 256
) (
   input  logic                         clk,
   input  logic                         load_en,
   input  logic [$clog2(ROM_WORDS)-1:0] load_addr,
   input  word_t                        load_data,
   input  word_t                        fetch_addr,
   output word_t                        fetch_word
);

   localparam int ADDR_W = $clog2(ROM_WORDS);

   // Program storage, contents come only from the boot loader
   word_t mem [ROM_WORDS];

   // Word index taken from the byte address
   logic [ADDR_W-1:0] rd_idx;

   // Drop the byte bit, upper bits wrap modulo the depth
   assign rd_idx = fetch_addr[ADDR_W:1];

   // Boot-load write, lands at the clock edge
   always_ff @(posedge clk) begin
      if (load_en) begin
         mem[load_addr] <= load_data;
      end
   end

   // Fetch read is combinational so the fetch stage sees the word in the same cycle
   assign fetch_word = mem[rd_idx];

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the front-end testbench with Verilator, run it and check for the pass line
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module tb_fetch \
   -f sim.f \
   -o tb_fetch_sim

status=0
output=$(./obj_dir/tb_fetch_sim 2>&1) || status=$?
echo "$output"

if [ "$status" -eq 0 ] && grep -qx "sim passed" <<< "$output"; then
   exit 0
fi

echo "Simulation did not report success"
exit 1

// ==== sim.f ====
hw/fetch_pkg.sv
hw/instr_rom.sv
hw/fetch_unit.sv
hw/if_id_reg.sv
hw/decode_unit.sv
hw/fetch_top.sv
testbench/tb_fetch.sv

// ==== testbench/tb_fetch.sv ====
// Testbench for the processor front end with random program and stall checked against a flow model
`timescale 1ns/10ps

module tb_fetch
   import fetch_pkg::*;
;

   localparam int ROM_WORDS  = 256;
   localparam int NUM_CHECKS = 2000;
   // Longest run of cycles allowed between two decoded bundles
   localparam int WAIT_LIMIT = 100;

   logic                         clk;
   logic                         rst;
   logic                         stall;
   logic                         load_en;
   logic [$clog2(ROM_WORDS)-1:0] load_addr;
   word_t                        load_data;
   decoded_t                     dec_out;

   // Program image as seen by the model
   word_t    model_mem [ROM_WORDS];
   word_t    model_pc;
   decoded_t exp_q [$];

   logic [15:0] lfsr_state;
   int          errors;
   int          timeouts;
   int          checked;
   int          jumps;
   int          stalled_jumps;

   fetch_top #(
      .ROM_WORDS (ROM_WORDS)
   ) dut_i (
      .clk       (clk),
      .rst       (rst),
      .stall     (stall),
      .load_en   (load_en),
      .load_addr (load_addr),
      .load_data (load_data),
      .dec_out   (dec_out)
   );

   // 40 ns clock
   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // Galois step with taps for x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      logic lsb;
      lsb = s[0];
      s   = s >> 1;
      if (lsb) begin
         s = s ^ 16'hB400;
      end
      return s;
   endfunction

   // Take n bits with one LFSR step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] val;
      val = '0;
      for (int k = 0; k < n; k++) begin
         lfsr_state = lfsr_next(lfsr_state);
         val        = {val[30:0], lfsr_state[0]};
      end
      return val;
   endfunction

   // Random word where one in eight becomes a forward jump
   function automatic word_t make_word();
      word_t w;
      w = 16'(rand_bits(16));
      if (rand_bits(3) == 32'd0) begin
         w[15:12] = 4'hD;
         w[7]     = 1'b0;
      end
      return w;
   endfunction

   // Expected bundle for the word at pc from the instruction set rules
   function automatic decoded_t model_decode(input word_t pc, input word_t w);
      decoded_t   d;
      logic [3:0] opc;
      word_t      sx;
      opc       = w[15:12];
      sx        = {{8{w[7]}}, w[7:0]};
      d         = '0;
      d.valid   = 1'b1;
      d.pc      = pc;
      d.opcode  = opcode_e'(opc);
      d.alu_op  = ALU_PASS;
      if (opc < 4'd8) begin
         // ALU ops keep their opcode order
         d.alu_op = alu_op_e'(opc);
         d.rd     = w[11:8];
         d.rs     = w[7:4];
         d.rt     = w[3:0];
      end else begin
         case (opc)
            4'd8, 4'd10, 4'd11: begin
               d.alu_op   = ALU_ADD;
               d.rd       = w[11:8];
               d.imm      = sx;
               d.uses_imm = 1'b1;
               d.is_load  = (opc == 4'd10);
               d.is_store = (opc == 4'd11);
            end
            4'd9: begin
               d.rd       = w[11:8];
               d.imm      = {w[7:0], 8'h00};
               d.uses_imm = 1'b1;
            end
            4'd13: begin
               // jmp reports its byte offset
               d.imm     = {sx[14:0], 1'b0};
               d.is_jump = 1'b1;
            end
            4'd15:   d.illegal = 1'b0;
            default: d.illegal = 1'b1;
         endcase
      end
      return d;
   endfunction

   // Keep a few expected bundles ahead along the jump path
   task automatic fill_queue();
      decoded_t d;
      while (exp_q.size() < 4) begin
         d = model_decode(model_pc, model_mem[model_pc[8:1]]);
         exp_q.push_back(d);
         if (d.is_jump) begin
            model_pc = model_pc + 16'd2 + d.imm;
         end else begin
            model_pc = model_pc + 16'd2;
         end
      end
   endtask

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] want);
      if (got !== want) begin
         errors++;
         $display("Fail at %0d ns: %s is %h, expected %h", $time, what, got, want);
      end
   endtask

   task automatic compare_bundle(input decoded_t got, input decoded_t want);
      string tag;
      tag = $sformatf("bundle for pc %h:", want.pc);
      check_value({tag, " valid"}, 32'(got.valid), 32'(want.valid));
      check_value({tag, " pc"}, 32'(got.pc), 32'(want.pc));
      check_value({tag, " opcode"}, 32'(got.opcode), 32'(want.opcode));
      check_value({tag, " alu_op"}, 32'(got.alu_op), 32'(want.alu_op));
      check_value({tag, " rd"}, 32'(got.rd), 32'(want.rd));
      check_value({tag, " rs"}, 32'(got.rs), 32'(want.rs));
      check_value({tag, " rt"}, 32'(got.rt), 32'(want.rt));
      check_value({tag, " imm"}, 32'(got.imm), 32'(want.imm));
      check_value({tag, " uses_imm"}, 32'(got.uses_imm), 32'(want.uses_imm));
      check_value({tag, " is_load"}, 32'(got.is_load), 32'(want.is_load));
      check_value({tag, " is_store"}, 32'(got.is_store), 32'(want.is_store));
      check_value({tag, " is_jump"}, 32'(got.is_jump), 32'(want.is_jump));
      check_value({tag, " illegal"}, 32'(got.illegal), 32'(want.illegal));
   endtask

   // One clock with a new random stall after the edge and the output check at the falling edge
   task automatic step_cycle(output logic edge_stall);
      @(posedge clk);
      edge_stall = stall;
      stall <= (rand_bits(2) == 32'd0);
      @(negedge clk);
      if (edge_stall) begin
         check_value("dec_out.valid on a stalled edge", 32'(dec_out.valid), 32'd0);
      end
   endtask

   // Wait for the next valid bundle and count the edges that moved the pipe
   task automatic wait_bundle(input int gap, input word_t want_pc, output logic found,
                              output decoded_t got);
      logic st;
      logic prev_st;
      int   moved;
      int   waited;
      found   = 1'b0;
      prev_st = 1'b0;
      moved   = 0;
      waited  = 0;
      got     = '0;
      while (!found && waited < WAIT_LIMIT) begin
         step_cycle(st);
         waited++;
         if (!st) begin
            moved++;
         end
         if (dec_out.valid) begin
            found = 1'b1;
            got   = dec_out;
            // A jump that sat in decode through a stall
            if (dec_out.is_jump && prev_st) begin
               stalled_jumps++;
            end
         end
         prev_st = st;
      end
      if (!found) begin
         timeouts++;
         $display("Timeout: no decoded bundle within %0d cycles while waiting for pc %h",
                  WAIT_LIMIT, want_pc);
      end else begin
         // Stalled edges only delay so the moving edge count is fixed
         check_value($sformatf("moving edges before pc %h", want_pc), 32'(moved), 32'(gap));
      end
   endtask

   // Clock with reset high where the decoded output stays invalid
   task automatic reset_cycle();
      @(negedge clk);
      check_value("dec_out.valid during reset", 32'(dec_out.valid), 32'd0);
   endtask

   initial begin
      decoded_t got;
      decoded_t want;
      logic     ok;
      int       gap;
      word_t    w;

      rst           = 1'b1;
      stall         = 1'b0;
      load_en       = 1'b0;
      load_addr     = '0;
      load_data     = '0;
      lfsr_state    = 16'd555;
      errors        = 0;
      timeouts      = 0;
      checked       = 0;
      jumps         = 0;
      stalled_jumps = 0;

      // Boot load of the whole memory under reset
      for (int i = 0; i < ROM_WORDS; i++) begin
         @(posedge clk);
         w            = make_word();
         model_mem[i] = w;
         load_en     <= 1'b1;
         load_addr   <= 8'(i);
         load_data   <= w;
         reset_cycle();
      end
      @(posedge clk);
      load_en <= 1'b0;
      reset_cycle();

      // Reset held four more cycles after the load
      repeat (4) begin
         @(posedge clk);
         reset_cycle();
      end
      @(posedge clk);
      rst <= 1'b0;

      // First bundle at pc 0 after two moving edges
      model_pc = '0;
      gap      = 2;
      while (checked < NUM_CHECKS && timeouts == 0) begin
         fill_queue();
         wait_bundle(gap, exp_q[0].pc, ok, got);
         if (ok) begin
            want = exp_q.pop_front();
            compare_bundle(got, want);
            checked++;
            if (want.is_jump) begin
               jumps++;
            end
            // One bubble behind a jump
            gap = want.is_jump ? 2 : 1;
         end
      end

      $display("Checked %0d instructions (%0d jumps, %0d after stall), %0d errors, %0d timeouts",
               checked, jumps, stalled_jumps, errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule
